// File: trap_mon_pkg.sv
//////////////////////////////////////////////////////////////////////
// Trap monitor package
// Shared widths, exception kind and cause encodings, and the packed
// probe structs that the trap and retirement monitor blocks exchange
//////////////////////////////////////////////////////////////////////

package trap_mon_pkg;

  // Address and data width of the observed core
  localparam int unsigned XLEN = 32;
  // Width of the mcause exception code field
  localparam int unsigned EXC_CODE_W = 6;
  // Number of synchronous exception kinds that are tracked
  localparam int unsigned NUM_EXC_KINDS = 5;
  localparam int unsigned EXC_KIND_W = 3;
  // Memory type attribute on the fetch and data buses
  localparam int unsigned MEMTYPE_W = 2;
  // Bit of the memory type field that marks a bufferable access
  localparam int unsigned MEMTYPE_BUFFERABLE = 0;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Tracked kinds in writeback priority order, also used as slot index
  typedef enum logic [EXC_KIND_W-1:0] {
    EXC_INSTR_FAULT     = 3'd0,
    EXC_INSTR_BUS_FAULT = 3'd1,
    EXC_ILLEGAL         = 3'd2,
    EXC_ECALL           = 3'd3,
    EXC_EBREAK          = 3'd4
  } exc_kind_e;

  // Synchronous exception codes as written to mcause
  typedef enum logic [EXC_CODE_W-1:0] {
    CAUSE_INSTR_FAULT     = 6'd1,
    CAUSE_ILLEGAL_INSN    = 6'd2,
    CAUSE_BREAKPOINT      = 6'd3,
    CAUSE_ECALL_MMODE     = 6'd11,
    CAUSE_INSTR_BUS_FAULT = 6'd24
  } exc_cause_e;

  // Single step retirement tracking
  typedef enum logic {
    STEP_IDLE  = 1'b0,
    STEP_ARMED = 1'b1
  } step_state_e;

  //////////////////////////////////////////////////////////////////////
  // Probe and status structs
  //////////////////////////////////////////////////////////////////////

  // One status bit per tracked kind
  typedef struct packed {
    logic instr_fault;
    logic instr_bus_fault;
    logic illegal;
    logic ecall;
    logic ebreak;
  } exc_flags_t;

  // Instruction in the writeback stage
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            illegal;
    logic            ecall;
    logic            ebreak;
    logic            bus_err;
    logic            mpu_err;
  } wb_instr_t;

  // Controller levels that suppress exception tracking
  typedef struct packed {
    logic irq_ack;
    logic debug_pending;
    logic nmi_trap;
    logic debug_mode_n;
    logic debug_mode;
  } ctrl_status_t;

  // CSR cause save strobe with the new cause and mepc value
  typedef struct packed {
    logic            save_cause;
    logic            irq;
    exc_cause_e      code;
    logic [XLEN-1:0] mepc_n;
  } csr_save_t;

  // A captured PC together with its valid marker
  typedef struct packed {
    logic            found;
    logic [XLEN-1:0] pc;
  } pc_slot_t;

  // Sticky bus attribute violations
  typedef struct packed {
    logic fetch_misaligned;
    logic fetch_bufferable;
    logic load_bufferable;
  } attr_flags_t;

endpackage

// File: expected_pc_tracker.sv
//////////////////////////////////////////////////////////////////////
// Expected PC tracker
// Classifies every qualifying writeback instruction into one
// exception kind and keeps the PC of the first one of each kind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module expected_pc_tracker (
  input  logic                                                 clk,
  input  logic                                                 rst_ni,
  input  trap_mon_pkg::wb_instr_t                              wb_i,
  input  trap_mon_pkg::ctrl_status_t                           ctrl_i,
  output trap_mon_pkg::pc_slot_t [trap_mon_pkg::NUM_EXC_KINDS-1:0] slots_o
);

  import trap_mon_pkg::*;

  logic                     wb_qualify;
  logic                     wb_hit;
  exc_kind_e                wb_kind;
  logic [NUM_EXC_KINDS-1:0] capture;
  logic [NUM_EXC_KINDS-1:0] found_q;
  logic [XLEN-1:0]          pc_q [NUM_EXC_KINDS];

  // An instruction in writeback only traps synchronously when no
  // interrupt, debug entry or NMI takes the pipeline at the same time
  assign wb_qualify = wb_i.valid & ~ctrl_i.irq_ack & ~ctrl_i.debug_pending &
                      ~ctrl_i.nmi_trap & ~ctrl_i.debug_mode_n;

  // Several error bits may be set together, the highest priority wins
  always_comb begin
    wb_hit  = wb_qualify;
    wb_kind = EXC_INSTR_FAULT;
    if (wb_i.mpu_err) begin
      wb_kind = EXC_INSTR_FAULT;
    end else if (wb_i.bus_err) begin
      wb_kind = EXC_INSTR_BUS_FAULT;
    end else if (wb_i.illegal) begin
      wb_kind = EXC_ILLEGAL;
    end else if (wb_i.ecall) begin
      wb_kind = EXC_ECALL;
    end else if (wb_i.ebreak) begin
      wb_kind = EXC_EBREAK;
    end else begin
      wb_hit = 1'b0;
    end
  end

  // Only the first instruction of each kind is kept
  always_comb begin
    capture = '0;
    if (wb_hit) begin
      capture[wb_kind] = ~found_q[wb_kind];
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  // PC storage, qualified by the found bits
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      if (capture[k]) begin
        pc_q[k] <= wb_i.pc;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      slots_o[k].found = found_q[k];
      slots_o[k].pc    = pc_q[k];
    end
  end

endmodule

// File: cause_pc_tracker.sv
//////////////////////////////////////////////////////////////////////
// Cause PC tracker
// Decodes synchronous cause saves and keeps the first mepc value
// written for each tracked exception kind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cause_pc_tracker (
  input  logic                                                 clk,
  input  logic                                                 rst_ni,
  input  trap_mon_pkg::csr_save_t                              csr_i,
  output trap_mon_pkg::pc_slot_t [trap_mon_pkg::NUM_EXC_KINDS-1:0] slots_o
);

  import trap_mon_pkg::*;

  logic                     cause_hit;
  exc_kind_e                cause_kind;
  logic [NUM_EXC_KINDS-1:0] capture;
  logic [NUM_EXC_KINDS-1:0] found_q;
  logic [XLEN-1:0]          mepc_q [NUM_EXC_KINDS];

  // Interrupt saves are ignored, as are codes outside the tracked set
  always_comb begin
    cause_hit  = csr_i.save_cause & ~csr_i.irq;
    cause_kind = EXC_INSTR_FAULT;
    case (csr_i.code)
      CAUSE_INSTR_FAULT:     cause_kind = EXC_INSTR_FAULT;
      CAUSE_INSTR_BUS_FAULT: cause_kind = EXC_INSTR_BUS_FAULT;
      CAUSE_ILLEGAL_INSN:    cause_kind = EXC_ILLEGAL;
      CAUSE_ECALL_MMODE:     cause_kind = EXC_ECALL;
      CAUSE_BREAKPOINT:      cause_kind = EXC_EBREAK;
      default:               cause_hit  = 1'b0;
    endcase
  end

  // First save of each kind fills its slot
  always_comb begin
    capture = '0;
    if (cause_hit) begin
      capture[cause_kind] = ~found_q[cause_kind];
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      if (capture[k]) begin
        mepc_q[k] <= csr_i.mepc_n;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      slots_o[k].found = found_q[k];
      slots_o[k].pc    = mepc_q[k];
    end
  end

endmodule

// File: mepc_compare.sv
//////////////////////////////////////////////////////////////////////
// mepc comparator
// Compares expected and saved PCs per kind once both are captured
// and holds sticky checked and mismatch flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mepc_compare (
  input  logic                                                 clk,
  input  logic                                                 rst_ni,
  input  trap_mon_pkg::pc_slot_t [trap_mon_pkg::NUM_EXC_KINDS-1:0] exp_i,
  input  trap_mon_pkg::pc_slot_t [trap_mon_pkg::NUM_EXC_KINDS-1:0] act_i,
  output trap_mon_pkg::exc_flags_t                             checked_o,
  output trap_mon_pkg::exc_flags_t                             mismatch_o
);

  import trap_mon_pkg::*;

  logic [NUM_EXC_KINDS-1:0] both_found;
  logic [NUM_EXC_KINDS-1:0] checked_q;
  logic [NUM_EXC_KINDS-1:0] mismatch_q;

  // Maps a kind indexed vector onto the named flag fields
  function automatic exc_flags_t to_flags(input logic [NUM_EXC_KINDS-1:0] vec);
    exc_flags_t flags;
    flags.instr_fault     = vec[EXC_INSTR_FAULT];
    flags.instr_bus_fault = vec[EXC_INSTR_BUS_FAULT];
    flags.illegal         = vec[EXC_ILLEGAL];
    flags.ecall           = vec[EXC_ECALL];
    flags.ebreak          = vec[EXC_EBREAK];
    return flags;
  endfunction

  always_comb begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      both_found[k] = exp_i[k].found & act_i[k].found;
    end
  end

  // The comparison happens once per kind, both slots are frozen by then
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= '0;
      mismatch_q <= '0;
    end else begin
      for (int k = 0; k < NUM_EXC_KINDS; k++) begin
        if (both_found[k] && !checked_q[k]) begin
          checked_q[k]  <= 1'b1;
          mismatch_q[k] <= (exp_i[k].pc != act_i[k].pc);
        end
      end
    end
  end

  assign checked_o  = to_flags(checked_q);
  assign mismatch_o = to_flags(mismatch_q);

endmodule

// File: step_retire_checker.sv
//////////////////////////////////////////////////////////////////////
// Single step retirement checker
// Flags a second retirement under single step that happens before
// the core has entered debug mode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module step_retire_checker (
  input  logic clk,
  input  logic rst_ni,
  input  logic dcsr_step_i,
  input  logic wb_valid_i,
  input  logic last_op_i,
  input  logic debug_mode_i,
  output logic step_violation_o
);

  import trap_mon_pkg::*;

  step_state_e state_q;
  step_state_e state_d;
  logic        retire_step;
  logic        violation_q;
  logic        violation_d;

  // Last operation of an instruction retiring while stepping in normal mode
  assign retire_step = wb_valid_i & last_op_i & dcsr_step_i & ~debug_mode_i;

  always_comb begin
    state_d     = state_q;
    violation_d = violation_q;
    case (state_q)
      STEP_IDLE: begin
        if (retire_step) begin
          state_d = STEP_ARMED;
        end
      end
      STEP_ARMED: begin
        // The next retirement must already belong to debug mode
        if (wb_valid_i) begin
          state_d = STEP_IDLE;
          if (!debug_mode_i) begin
            violation_d = 1'b1;
          end
        end
      end
      default: state_d = STEP_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= STEP_IDLE;
      violation_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      violation_q <= violation_d;
    end
  end

  assign step_violation_o = violation_q;

endmodule

// File: bus_attr_checker.sv
//////////////////////////////////////////////////////////////////////
// Bus attribute checker
// Sticky flags for misaligned or bufferable fetches and for
// bufferable loads on the data bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_attr_checker (
  input  logic                                 clk,
  input  logic                                 rst_ni,
  input  logic [trap_mon_pkg::XLEN-1:0]        fetch_addr_i,
  input  logic [trap_mon_pkg::MEMTYPE_W-1:0]   fetch_memtype_i,
  input  logic                                 data_req_i,
  input  logic                                 data_we_i,
  input  logic [trap_mon_pkg::MEMTYPE_W-1:0]   data_memtype_i,
  output trap_mon_pkg::attr_flags_t            attr_o
);

  import trap_mon_pkg::*;

  attr_flags_t attr_q;
  logic        load_req;

  // Stores may be bufferable, loads may not
  assign load_req = data_req_i & ~data_we_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      attr_q <= '0;
    end else begin
      // Fetches are always word aligned on this core
      if (|fetch_addr_i[1:0]) begin
        attr_q.fetch_misaligned <= 1'b1;
      end
      if (fetch_memtype_i[MEMTYPE_BUFFERABLE]) begin
        attr_q.fetch_bufferable <= 1'b1;
      end
      if (load_req && data_memtype_i[MEMTYPE_BUFFERABLE]) begin
        attr_q.load_bufferable <= 1'b1;
      end
    end
  end

  assign attr_o = attr_q;

endmodule

// File: trap_mon_top.sv
//////////////////////////////////////////////////////////////////////
// Trap and retirement monitor
// Observes the core probes, checks mepc against the trapping PC,
// single step retirement and bus attributes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module trap_mon_top (
  input  logic                                 clk,
  input  logic                                 rst_ni,
  input  trap_mon_pkg::wb_instr_t              wb_i,
  input  trap_mon_pkg::ctrl_status_t           ctrl_i,
  input  trap_mon_pkg::csr_save_t              csr_i,
  input  logic                                 dcsr_step_i,
  input  logic                                 wb_valid_i,
  input  logic                                 last_op_i,
  input  logic [trap_mon_pkg::XLEN-1:0]        fetch_addr_i,
  input  logic [trap_mon_pkg::MEMTYPE_W-1:0]   fetch_memtype_i,
  input  logic                                 data_req_i,
  input  logic                                 data_we_i,
  input  logic [trap_mon_pkg::MEMTYPE_W-1:0]   data_memtype_i,
  output trap_mon_pkg::exc_flags_t             checked_o,
  output trap_mon_pkg::exc_flags_t             mismatch_o,
  output logic                                 step_violation_o,
  output trap_mon_pkg::attr_flags_t            attr_o
);

  import trap_mon_pkg::*;

  // First trapping PC per kind, seen from writeback and from the CSRs
  pc_slot_t [NUM_EXC_KINDS-1:0] exp_slots;
  pc_slot_t [NUM_EXC_KINDS-1:0] act_slots;

  expected_pc_tracker u_expected_pc_tracker (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .wb_i    (wb_i),
    .ctrl_i  (ctrl_i),
    .slots_o (exp_slots)
  );

  cause_pc_tracker u_cause_pc_tracker (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .csr_i   (csr_i),
    .slots_o (act_slots)
  );

  mepc_compare u_mepc_compare (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .exp_i      (exp_slots),
    .act_i      (act_slots),
    .checked_o  (checked_o),
    .mismatch_o (mismatch_o)
  );

  step_retire_checker u_step_retire_checker (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .dcsr_step_i      (dcsr_step_i),
    .wb_valid_i       (wb_valid_i),
    .last_op_i        (last_op_i),
    .debug_mode_i     (ctrl_i.debug_mode),
    .step_violation_o (step_violation_o)
  );

  bus_attr_checker u_bus_attr_checker (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_memtype_i (fetch_memtype_i),
    .data_req_i      (data_req_i),
    .data_we_i       (data_we_i),
    .data_memtype_i  (data_memtype_i),
    .attr_o          (attr_o)
  );

endmodule

// File: tb_trap_mon.sv
//////////////////////////////////////////////////////////////////////
// Trap monitor testbench
// Drives writeback, cause save, single step and bus probes into the
// monitor and checks its status flags against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_trap_mon;

  import trap_mon_pkg::*;

  // Five short tests of well under 100 cycles each, with a wide margin
  localparam int unsigned MAX_CYCLES = 2000;
  localparam logic [31:0] LFSR_SEED = 32'h59252951;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic clk = 1'b0;
  logic rst_ni;
  wb_instr_t wb_i;
  ctrl_status_t ctrl_i;
  csr_save_t csr_i;
  logic dcsr_step_i, wb_valid_i, last_op_i;
  logic [XLEN-1:0] fetch_addr_i;
  logic [MEMTYPE_W-1:0] fetch_memtype_i, data_memtype_i;
  logic data_req_i, data_we_i;
  exc_flags_t checked_o, mismatch_o;
  logic step_violation_o;
  attr_flags_t attr_o;

  logic [31:0] lfsr_q = LFSR_SEED;
  int unsigned cycle_cnt = 0;
  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int test_err_start;
  logic [XLEN-1:0] pc_a, pc_b;
  logic [XLEN-1:0] ecall_pc;

  // Reference model state, indexed by exception kind
  logic [NUM_EXC_KINDS-1:0] exp_found, act_found, m_checked, m_mismatch;
  logic [XLEN-1:0] exp_pc [NUM_EXC_KINDS];
  logic [XLEN-1:0] act_pc [NUM_EXC_KINDS];
  logic m_armed, m_step_viol;
  attr_flags_t m_attr;
  exc_flags_t m_checked_f, m_mismatch_f;

  trap_mon_top u_dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per returned bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out_bit) begin
        lfsr_q = lfsr_q ^ LFSR_TAPS;
      end
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  // Kind index of a qualifying writeback instruction, or -1
  function automatic int wb_kind_of(input wb_instr_t wb, input ctrl_status_t c);
    if (!wb.valid || c.irq_ack || c.debug_pending || c.nmi_trap || c.debug_mode_n) return -1;
    if (wb.mpu_err) return int'(EXC_INSTR_FAULT);
    if (wb.bus_err) return int'(EXC_INSTR_BUS_FAULT);
    if (wb.illegal) return int'(EXC_ILLEGAL);
    if (wb.ecall) return int'(EXC_ECALL);
    if (wb.ebreak) return int'(EXC_EBREAK);
    return -1;
  endfunction

  // Kind index of a synchronous cause save, or -1
  function automatic int cause_kind_of(input csr_save_t c);
    if (!c.save_cause || c.irq) return -1;
    case (c.code)
      CAUSE_INSTR_FAULT:     return int'(EXC_INSTR_FAULT);
      CAUSE_INSTR_BUS_FAULT: return int'(EXC_INSTR_BUS_FAULT);
      CAUSE_ILLEGAL_INSN:    return int'(EXC_ILLEGAL);
      CAUSE_ECALL_MMODE:     return int'(EXC_ECALL);
      CAUSE_BREAKPOINT:      return int'(EXC_EBREAK);
      default:               return -1;
    endcase
  endfunction

  // The flag struct lists kinds from its top bit down
  function automatic exc_flags_t as_flags(input logic [NUM_EXC_KINDS-1:0] v);
    logic [NUM_EXC_KINDS-1:0] f;
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      f[NUM_EXC_KINDS-1-k] = v[k];
    end
    return exc_flags_t'(f);
  endfunction

  assign m_checked_f = as_flags(m_checked);
  assign m_mismatch_f = as_flags(m_mismatch);

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_ni) begin : model
    int wk;
    int ck;
    if (!rst_ni) begin
      exp_found <= '0;
      act_found <= '0;
      m_checked <= '0;
      m_mismatch <= '0;
      m_armed <= 1'b0;
      m_step_viol <= 1'b0;
      m_attr <= '0;
    end else begin
      wk = wb_kind_of(wb_i, ctrl_i);
      ck = cause_kind_of(csr_i);
      if (wk >= 0 && !exp_found[wk]) begin
        exp_found[wk] <= 1'b1;
        exp_pc[wk] <= wb_i.pc;
      end
      if (ck >= 0 && !act_found[ck]) begin
        act_found[ck] <= 1'b1;
        act_pc[ck] <= csr_i.mepc_n;
      end
      for (int k = 0; k < NUM_EXC_KINDS; k++) begin
        if (exp_found[k] && act_found[k] && !m_checked[k]) begin
          m_checked[k] <= 1'b1;
          m_mismatch[k] <= (exp_pc[k] != act_pc[k]);
        end
      end
      // A step retirement arms, the next retirement must be in debug mode
      if (m_armed) begin
        if (wb_valid_i) begin
          m_armed <= 1'b0;
          if (!ctrl_i.debug_mode) m_step_viol <= 1'b1;
        end
      end else if (wb_valid_i && last_op_i && dcsr_step_i && !ctrl_i.debug_mode) begin
        m_armed <= 1'b1;
      end
      if (fetch_addr_i[1:0] != 2'b00) m_attr.fetch_misaligned <= 1'b1;
      if (fetch_memtype_i[0]) m_attr.fetch_bufferable <= 1'b1;
      if (data_req_i && !data_we_i && data_memtype_i[0]) m_attr.load_bufferable <= 1'b1;
    end
  end

  a_checked: assert property (@(posedge clk) disable iff (!rst_ni) checked_o == m_checked_f)
    else begin
      $display("FAIL %0t: checked_o %b, expected %b", $time, $sampled(checked_o),
               $sampled(m_checked_f));
      err_cnt++;
    end
  a_mismatch: assert property (@(posedge clk) disable iff (!rst_ni) mismatch_o == m_mismatch_f)
    else begin
      $display("FAIL %0t: mismatch_o %b, expected %b", $time, $sampled(mismatch_o),
               $sampled(m_mismatch_f));
      err_cnt++;
    end
  a_step: assert property (@(posedge clk) disable iff (!rst_ni) step_violation_o == m_step_viol)
    else begin
      $display("FAIL %0t: step_violation_o %b, expected %b", $time,
               $sampled(step_violation_o), $sampled(m_step_viol));
      err_cnt++;
    end
  a_attr: assert property (@(posedge clk) disable iff (!rst_ni) attr_o == m_attr)
    else begin
      $display("FAIL %0t: attr_o %b, expected %b", $time, $sampled(attr_o), $sampled(m_attr));
      err_cnt++;
    end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic writeback(input logic [XLEN-1:0] pc, input logic mpu_err,
                           input logic bus_err, input logic illegal, input logic ecall,
                           input logic ebreak, input logic irq_ack);
    @(posedge clk);
    wb_i.valid <= 1'b1;
    wb_i.pc <= pc;
    wb_i.mpu_err <= mpu_err;
    wb_i.bus_err <= bus_err;
    wb_i.illegal <= illegal;
    wb_i.ecall <= ecall;
    wb_i.ebreak <= ebreak;
    ctrl_i.irq_ack <= irq_ack;
    @(posedge clk);
    wb_i <= '0;
    ctrl_i.irq_ack <= 1'b0;
  endtask

  task automatic save_cause(input logic irq, input exc_cause_e code, input logic [XLEN-1:0] mepc);
    @(posedge clk);
    csr_i.save_cause <= 1'b1;
    csr_i.irq <= irq;
    csr_i.code <= code;
    csr_i.mepc_n <= mepc;
    @(posedge clk);
    csr_i <= '0;
  endtask

  task automatic retire(input logic step, input logic dbg);
    @(posedge clk);
    wb_valid_i <= 1'b1;
    last_op_i <= 1'b1;
    dcsr_step_i <= step;
    ctrl_i.debug_mode <= dbg;
    @(posedge clk);
    wb_valid_i <= 1'b0;
    last_op_i <= 1'b0;
    ctrl_i.debug_mode <= 1'b0;
  endtask

  task automatic bus_cycle(input logic [XLEN-1:0] addr, input logic [MEMTYPE_W-1:0] f_type,
                           input logic req, input logic we, input logic [MEMTYPE_W-1:0] d_type);
    @(posedge clk);
    fetch_addr_i <= addr;
    fetch_memtype_i <= f_type;
    data_req_i <= req;
    data_we_i <= we;
    data_memtype_i <= d_type;
    @(posedge clk);
    fetch_addr_i <= '0;
    fetch_memtype_i <= '0;
    data_req_i <= 1'b0;
    data_we_i <= 1'b0;
    data_memtype_i <= '0;
  endtask

  task automatic wait_checked(input exc_flags_t mask);
    @(negedge clk);
    while ((checked_o & mask) != mask) @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
      else begin
        $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
        err_cnt++;
      end
  endtask

  task automatic report_test(input string name);
    if (err_cnt == test_err_start) begin
      pass_cnt++;
      $display("Test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d errors", name, err_cnt - test_err_start);
    end
    test_err_start = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    wb_i = '0;
    ctrl_i = '0;
    csr_i = '0;
    dcsr_step_i = 1'b0;
    wb_valid_i = 1'b0;
    last_op_i = 1'b0;
    fetch_addr_i = '0;
    fetch_memtype_i = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_memtype_i = '0;
    repeat (4) @(posedge clk);
    rst_ni <= 1'b1;
    test_err_start = err_cnt;

    // An ecall during an interrupt ack is not a trap
    // Its PC equals the mepc of the later ecall save, so a wrongly kept
    // slot would hide the expected mismatch
    ecall_pc = rand_bits(XLEN) & ~32'h3;
    writeback(ecall_pc + 32'd4, 0, 0, 0, 1, 0, 1);
    // mpu_err beats illegal
    pc_a = rand_bits(XLEN) & ~32'h3;
    writeback(pc_a, 1, 0, 1, 0, 0, 0);
    save_cause(0, CAUSE_INSTR_FAULT, pc_a);
    wait_checked(exc_flags_t'(5'b10000));
    check_value("mismatch_o", 8'(mismatch_o), 8'h00);
    report_test("priority_gating");

    pc_a = rand_bits(XLEN) & ~32'h3;
    pc_b = rand_bits(XLEN) & ~32'h3;
    writeback(pc_a, 0, 0, 1, 0, 0, 0);
    save_cause(0, CAUSE_ILLEGAL_INSN, pc_a);
    writeback(pc_b, 0, 0, 0, 0, 1, 0);
    save_cause(0, CAUSE_BREAKPOINT, pc_b);
    wait_checked(exc_flags_t'(5'b00101));
    check_value("mismatch_o", 8'(mismatch_o), 8'h00);
    report_test("matching_traps");

    writeback(ecall_pc, 0, 0, 0, 1, 0, 0);
    save_cause(0, CAUSE_ECALL_MMODE, ecall_pc + 32'd4);
    wait_checked(exc_flags_t'(5'b00010));
    check_value("mismatch_o.ecall", 8'(mismatch_o.ecall), 8'h01);
    // An interrupt save with the bus fault code must leave the slot empty
    save_cause(1, CAUSE_INSTR_BUS_FAULT, rand_bits(XLEN) & ~32'h3);
    pc_b = rand_bits(XLEN) & ~32'h3;
    writeback(pc_b, 0, 1, 0, 0, 0, 0);
    save_cause(0, CAUSE_INSTR_BUS_FAULT, pc_b);
    wait_checked(exc_flags_t'(5'b01000));
    check_value("mismatch_o.instr_bus_fault", 8'(mismatch_o.instr_bus_fault), 8'h00);
    report_test("mismatch");

    retire(1, 0);
    retire(1, 1);
    idle_cycles(3);
    check_value("step_violation_o", 8'(step_violation_o), 8'h00);
    retire(1, 0);
    retire(1, 0);
    idle_cycles(2);
    check_value("step_violation_o", 8'(step_violation_o), 8'h01);
    report_test("single_step");

    bus_cycle('0, 2'b00, 1, 1, 2'b01);
    idle_cycles(2);
    check_value("attr_o", 8'(attr_o), 8'h00);
    bus_cycle((rand_bits(XLEN) & ~32'h3) | 32'h2, 2'b00, 0, 0, 2'b00);
    idle_cycles(2);
    check_value("attr_o", 8'(attr_o), 8'h04);
    bus_cycle('0, 2'b01, 0, 0, 2'b00);
    idle_cycles(2);
    check_value("attr_o", 8'(attr_o), 8'h06);
    bus_cycle('0, 2'b00, 1, 0, 2'b01);
    idle_cycles(2);
    check_value("attr_o", 8'(attr_o), 8'h07);
    report_test("bus_attributes");

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: trap_mon.f
trap_mon_pkg.sv
expected_pc_tracker.sv
cause_pc_tracker.sv
mepc_compare.sv
step_retire_checker.sv
bus_attr_checker.sv
trap_mon_top.sv
tb_trap_mon.sv
